// File: logic/seq_pkg.sv
/*
  Shared widths, opcodes and payload types for the sequence tracker
  Window is two epochs of eight numbers, so at most 15 are outstanding
*/

package seq_pkg;

  // ----------------------------
  // Sequence number window
  // ----------------------------

  localparam int SEQ_NUM_BITS = 4;
  localparam int NUM_EPOCHS   = 2;
  localparam int EPOCH_BITS   = $clog2(NUM_EPOCHS);
  // Bits below the epoch field
  localparam int SEQ_LOW_BITS = SEQ_NUM_BITS - EPOCH_BITS;
  localparam int NUM_ENTRIES  = 2 ** SEQ_NUM_BITS;

  // ----------------------------
  // Datapath widths
  // ----------------------------

  localparam int OPND_BITS = 8;
  localparam int DATA_BITS = 16;
  // Opcode in the top two bits, then operand a, then operand b
  localparam int INST_BITS = 2 + 2 * OPND_BITS;

  typedef logic [SEQ_NUM_BITS-1:0] seq_num_t;

  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_XOR = 2'b10,
    OP_MUL = 2'b11
  } op_t;

  // Operands already zero-extended to the result width
  typedef struct packed {
    op_t                  op;
    logic [DATA_BITS-1:0] a;
    logic [DATA_BITS-1:0] b;
    seq_num_t             seq_num;
  } dec_op_t;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    seq_num_t             seq_num;
  } result_t;

endpackage

// File: logic/sequencing_unit.sv
/*
  Hands out sequence numbers in order and reclaims freed ones from the tail
  Allocation stalls before the head wraps into the oldest live epoch
  Only numbers that were allocated may be freed, each exactly once
*/

`timescale 1ns/100ps

module sequencing_unit #(
  parameter int reclaim_width = 2
) (
  input  logic                           clk,
  input  logic                           rst,

  // Allocation side
  output logic                           alloc_val,
  input  logic                           alloc_rdy,
  output seq_pkg::seq_num_t              alloc_seq_num,

  // Free side, one pulse per number with no back-pressure
  input  logic                           free_val,
  input  seq_pkg::seq_num_t              free_seq_num,

  // Oldest live epoch
  output logic [seq_pkg::EPOCH_BITS-1:0] tail_epoch
);

  import seq_pkg::*;

  // Epoch field of a sequence number
  function automatic logic [EPOCH_BITS-1:0] epoch_of(input seq_num_t seq_num);
    return seq_num[SEQ_NUM_BITS-1 -: EPOCH_BITS];
  endfunction

  // ----------------------------
  // Pointers and entry flags
  // ----------------------------

  seq_num_t               head_ptr;
  seq_num_t               tail_ptr;
  // One per number, set while allocated and not yet freed
  logic [NUM_ENTRIES-1:0] live;

  logic                   alloc_fire;
  logic [EPOCH_BITS-1:0]  head_epoch_next;
  seq_num_t               entries_allocated;
  seq_num_t               tail_incr;

  // ----------------------------
  // Allocation
  // ----------------------------

  // Epoch that the head enters after its low bits roll over
  assign head_epoch_next = epoch_of(head_ptr) + 1'b1;

  // Block when the next number would land in the tail's epoch
  assign alloc_val = !((&head_ptr[SEQ_LOW_BITS-1:0]) &&
                       (head_epoch_next == epoch_of(tail_ptr)));

  assign alloc_fire    = alloc_val && alloc_rdy;
  assign alloc_seq_num = head_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
    end else if (alloc_fire) begin
      head_ptr <= head_ptr + 1'b1;
    end
  end

  // Set on allocation, cleared on free
  always_ff @(posedge clk) begin
    if (rst) begin
      live <= '0;
    end else begin
      if (alloc_fire) begin
        live[head_ptr] <= 1'b1;
      end
      if (free_val) begin
        live[free_seq_num] <= 1'b0;
      end
    end
  end

  // ----------------------------
  // Reclaim
  // ----------------------------

  // Outstanding count, never reaches 16
  assign entries_allocated = head_ptr - tail_ptr;

  // Longest run of freed entries from the tail, capped at reclaim_width
  always_comb begin
    seq_num_t idx;
    logic     run_ok;
    run_ok    = 1'b1;
    tail_incr = '0;
    for (int i = 0; i < reclaim_width; i++) begin
      idx    = tail_ptr + SEQ_NUM_BITS'(i);
      // Entry must be inside the allocated range and already freed
      run_ok = run_ok && !live[idx] && (SEQ_NUM_BITS'(i) < entries_allocated);
      if (run_ok) begin
        tail_incr = SEQ_NUM_BITS'(i + 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr <= '0;
    end else begin
      tail_ptr <= tail_ptr + tail_incr;
    end
  end

  // ----------------------------
  // Age
  // ----------------------------

  assign tail_epoch = epoch_of(tail_ptr);

endmodule

// File: logic/skid_buffer.sv
/*
  Two-entry valid/ready buffer, output and in_rdy both come from flops
  Sustains one transfer per cycle, adds one cycle of latency
*/

`timescale 1ns/100ps

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  input  logic     in_val,
  output logic     in_rdy,
  input  payload_t in_data,

  output logic     out_val,
  input  logic     out_rdy,
  output payload_t out_data
);

  logic     main_val;
  logic     skid_val;
  payload_t main_data;
  payload_t skid_data;

  logic     in_fire;
  logic     out_fire;
  logic     main_load;

  // Ready as long as the spare slot is empty
  assign in_rdy   = !skid_val;
  assign out_val  = main_val;
  assign out_data = main_data;

  assign in_fire  = in_val && in_rdy;
  assign out_fire = main_val && out_rdy;

  // Main slot refills when empty or draining
  assign main_load = !main_val || out_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      main_val <= 1'b0;
      skid_val <= 1'b0;
    end else if (main_load) begin
      // Spare slot drains first to keep order
      main_val <= skid_val || in_fire;
      skid_val <= 1'b0;
    end else if (in_fire) begin
      skid_val <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      main_data <= skid_val ? skid_data : in_data;
    end
    // Catch the word that arrives while main is stalled
    if (!main_load && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

// File: logic/op_decode.sv
/*
  Combinational decode of an operation word into a tagged operation
  A sequence number is consumed only together with the downstream transfer
*/

`timescale 1ns/100ps

module op_decode (
  // Operation words from outside
  input  logic                          inst_val,
  output logic                          inst_rdy,
  input  logic [seq_pkg::INST_BITS-1:0] inst,

  // Number from the sequencing unit
  input  logic                          alloc_val,
  output logic                          alloc_rdy,
  input  seq_pkg::seq_num_t             alloc_seq_num,

  // Decoded operation to the buffer
  output logic                          out_val,
  input  logic                          out_rdy,
  output seq_pkg::dec_op_t              out_op
);

  import seq_pkg::*;

  logic [OPND_BITS-1:0] opnd_a;
  logic [OPND_BITS-1:0] opnd_b;

  // ----------------------------
  // Field split
  // ----------------------------

  assign opnd_a = inst[2*OPND_BITS-1:OPND_BITS];
  assign opnd_b = inst[OPND_BITS-1:0];

  assign out_op.op      = op_t'(inst[INST_BITS-1 -: 2]);
  assign out_op.a       = DATA_BITS'(opnd_a);
  assign out_op.b       = DATA_BITS'(opnd_b);
  assign out_op.seq_num = alloc_seq_num;

  // ----------------------------
  // Handshake
  // ----------------------------

  // Offer downstream only with a number in hand
  assign out_val  = inst_val && alloc_val;

  // Word accepted only if the number and the buffer are both there
  assign inst_rdy = alloc_val && out_rdy;

  // Number taken in the same cycle as the downstream transfer
  assign alloc_rdy = inst_val && out_rdy;

endmodule

// File: logic/op_execute.sv
/*
  One-cycle ALU lane and three-stage multiply lane, in order within a lane
  Multiply result wins the shared output; both lanes freeze when out_rdy is low
*/

`timescale 1ns/100ps

module op_execute (
  input  logic             clk,
  input  logic             rst,

  input  logic             in_val,
  output logic             in_rdy,
  input  seq_pkg::dec_op_t in_op,

  output logic             out_val,
  input  logic             out_rdy,
  output seq_pkg::result_t out_res
);

  import seq_pkg::*;

  logic                   is_mul;
  logic                   alu_load;
  logic                   mul_load;
  logic                   alu_free;
  logic                   alu_out_fire;
  logic [DATA_BITS-1:0]   alu_data;

  // ALU stage
  logic                   alu_val;
  result_t                alu_res;

  // Multiply stages
  logic                   m1_val;
  logic                   m2_val;
  logic                   m3_val;
  logic [OPND_BITS-1:0]   m1_a;
  logic [OPND_BITS-1:0]   m1_b;
  seq_num_t               m1_seq;
  logic [OPND_BITS+3:0]   m2_pp_lo;
  logic [OPND_BITS+3:0]   m2_pp_hi;
  seq_num_t               m2_seq;
  result_t                m3_res;

  // ----------------------------
  // Issue
  // ----------------------------

  assign is_mul = (in_op.op == OP_MUL);

  // ALU slot free if empty or its result leaves now
  assign alu_out_fire = alu_val && !m3_val && out_rdy;
  assign alu_free     = !alu_val || alu_out_fire;

  assign in_rdy   = out_rdy && (is_mul || alu_free);
  assign alu_load = in_val && in_rdy && !is_mul;
  assign mul_load = in_val && in_rdy && is_mul;

  // ----------------------------
  // ALU lane
  // ----------------------------

  always_comb begin
    case (in_op.op)
      OP_ADD:  alu_data = in_op.a + in_op.b;
      OP_SUB:  alu_data = in_op.a - in_op.b;
      default: alu_data = in_op.a ^ in_op.b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_val <= 1'b0;
    end else if (alu_load) begin
      alu_val <= 1'b1;
    end else if (alu_out_fire) begin
      alu_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_load) begin
      alu_res.data    <= alu_data;
      alu_res.seq_num <= in_op.seq_num;
    end
  end

  // ----------------------------
  // Multiply lane
  // ----------------------------

  // Whole lane shifts only while the output can take a result
  always_ff @(posedge clk) begin
    if (rst) begin
      m1_val <= 1'b0;
      m2_val <= 1'b0;
      m3_val <= 1'b0;
    end else if (out_rdy) begin
      m1_val <= mul_load;
      m2_val <= m1_val;
      m3_val <= m2_val;
    end
  end

  always_ff @(posedge clk) begin
    if (out_rdy) begin
      // Stage 1 latches the low operand bytes
      m1_a   <= in_op.a[OPND_BITS-1:0];
      m1_b   <= in_op.b[OPND_BITS-1:0];
      m1_seq <= in_op.seq_num;
      // Stage 2 forms partial products on nibbles of b
      m2_pp_lo <= m1_a * m1_b[3:0];
      m2_pp_hi <= m1_a * m1_b[7:4];
      m2_seq   <= m1_seq;
      // Stage 3 sums them
      m3_res.data    <= DATA_BITS'(m2_pp_lo) + (DATA_BITS'(m2_pp_hi) << 4);
      m3_res.seq_num <= m2_seq;
    end
  end

  // ----------------------------
  // Merge
  // ----------------------------

  assign out_val = m3_val || alu_val;
  assign out_res = m3_val ? m3_res : alu_res;

endmodule

// File: logic/result_writeback.sv
/*
  Presents buffered results at the outputs
  Frees a result's sequence number in the cycle it is accepted
*/

`timescale 1ns/100ps

module result_writeback (
  // Buffered result
  input  logic                          in_val,
  output logic                          in_rdy,
  input  seq_pkg::result_t              in_res,

  // Result outputs
  output logic                          res_val,
  input  logic                          res_rdy,
  output logic [seq_pkg::DATA_BITS-1:0] res_data,
  output seq_pkg::seq_num_t             res_seq_num,

  // Free pulse to the sequencing unit
  output logic                          free_val,
  output seq_pkg::seq_num_t             free_seq_num
);

  logic out_fire;

  // Result held at the outputs until the consumer takes it
  assign res_val     = in_val;
  assign res_data    = in_res.data;
  assign res_seq_num = in_res.seq_num;
  assign in_rdy      = res_rdy;

  // ----------------------------
  // Free
  // ----------------------------

  assign out_fire = in_val && res_rdy;

  // Exactly one pulse per accepted result
  assign free_val     = out_fire;
  assign free_seq_num = in_res.seq_num;

endmodule

// File: logic/seq_tracker.sv
/*
  Sequence tracker top, results leave out of order tagged with their number
  Unstalled latency is 3 cycles for ALU ops and 5 for multiplies
*/

`timescale 1ns/100ps

module seq_tracker (
  input  logic                           clk,
  input  logic                           rst,

  input  logic                           inst_val,
  output logic                           inst_rdy,
  input  logic [seq_pkg::INST_BITS-1:0]  inst,

  output logic                           res_val,
  input  logic                           res_rdy,
  output logic [seq_pkg::DATA_BITS-1:0]  res_data,
  output seq_pkg::seq_num_t              res_seq_num,

  output logic [seq_pkg::EPOCH_BITS-1:0] tail_epoch
);

  import seq_pkg::*;

  // Allocation
  logic     alloc_val;
  logic     alloc_rdy;
  seq_num_t alloc_seq_num;

  // Decode to buffer, buffer to execute
  logic     dec_val;
  logic     dec_rdy;
  dec_op_t  dec_op;
  logic     exe_val;
  logic     exe_rdy;
  dec_op_t  exe_op;

  // Execute to buffer, buffer to writeback
  logic     exr_val;
  logic     exr_rdy;
  result_t  exr_res;
  logic     wb_val;
  logic     wb_rdy;
  result_t  wb_res;

  // Free
  logic     free_val;
  seq_num_t free_seq_num;

  // ----------------------------
  // Front end
  // ----------------------------

  op_decode op_decode_i (
    .inst_val      (inst_val),
    .inst_rdy      (inst_rdy),
    .inst          (inst),
    .alloc_val     (alloc_val),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .out_val       (dec_val),
    .out_rdy       (dec_rdy),
    .out_op        (dec_op)
  );

  skid_buffer #(.payload_t(dec_op_t)) dec_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_val   (dec_val),
    .in_rdy   (dec_rdy),
    .in_data  (dec_op),
    .out_val  (exe_val),
    .out_rdy  (exe_rdy),
    .out_data (exe_op)
  );

  // ----------------------------
  // Execute and results
  // ----------------------------

  op_execute op_execute_i (
    .clk     (clk),
    .rst     (rst),
    .in_val  (exe_val),
    .in_rdy  (exe_rdy),
    .in_op   (exe_op),
    .out_val (exr_val),
    .out_rdy (exr_rdy),
    .out_res (exr_res)
  );

  skid_buffer #(.payload_t(result_t)) res_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_val   (exr_val),
    .in_rdy   (exr_rdy),
    .in_data  (exr_res),
    .out_val  (wb_val),
    .out_rdy  (wb_rdy),
    .out_data (wb_res)
  );

  result_writeback result_writeback_i (
    .in_val       (wb_val),
    .in_rdy       (wb_rdy),
    .in_res       (wb_res),
    .res_val      (res_val),
    .res_rdy      (res_rdy),
    .res_data     (res_data),
    .res_seq_num  (res_seq_num),
    .free_val     (free_val),
    .free_seq_num (free_seq_num)
  );

  // ----------------------------
  // Sequence numbers
  // ----------------------------

  sequencing_unit sequencing_unit_i (
    .clk           (clk),
    .rst           (rst),
    .alloc_val     (alloc_val),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .free_val      (free_val),
    .free_seq_num  (free_seq_num),
    .tail_epoch    (tail_epoch)
  );

endmodule

// File: tests/seq_tracker_properties.sv
/*
  Port-level checks for the sequence tracker, bound to the top level
  Outstanding count is rebuilt here from the input and result handshakes
*/

`timescale 1ns/100ps

module seq_tracker_properties (
  input logic                          clk,
  input logic                          rst,
  input logic                          inst_val,
  input logic                          inst_rdy,
  input logic                          res_val,
  input logic                          res_rdy,
  input logic [seq_pkg::DATA_BITS-1:0] res_data,
  input seq_pkg::seq_num_t             res_seq_num
);

  import seq_pkg::*;

  localparam int CNT_BITS = SEQ_NUM_BITS + 1;

  logic [CNT_BITS-1:0] outstanding;

  // Accepted but not yet returned
  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + CNT_BITS'(inst_val && inst_rdy)
                                 - CNT_BITS'(res_val && res_rdy);
    end
  end

  // Output empty right after reset
  reset_clears_output: assert property (@(posedge clk) rst |=> !res_val)
    else $error("res_val high in the cycle after reset");

  // Stalled result held steady
  result_held_under_stall: assert property (@(posedge clk) disable iff (rst)
    res_val && !res_rdy |=> res_val && $stable(res_data) && $stable(res_seq_num))
    else $error("result changed or dropped while res_rdy was low");

  // Full window blocks new words
  window_blocks_input: assert property (@(posedge clk) disable iff (rst)
    outstanding >= CNT_BITS'(NUM_ENTRIES - 1) |-> !inst_rdy)
    else $error("inst_rdy high with 15 instructions outstanding");

endmodule

// File: tests/seq_tracker_tb.sv
/*
  Directed tests for the sequence tracker, the run stops at the first error
  Expected data comes from a table indexed by the number each word receives
*/

`timescale 1ns/100ps

module seq_tracker_tb;

  import seq_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int WAIT_LIMIT   = 200;
  localparam int STALL_CYCLES = 40;
  localparam int STREAM_COUNT = 200;

  logic                   clk;
  logic                   rst;
  logic                   inst_val;
  logic                   inst_rdy;
  logic [INST_BITS-1:0]   inst;
  logic                   res_val;
  logic                   res_rdy;
  logic [DATA_BITS-1:0]   res_data;
  seq_num_t               res_seq_num;
  logic [EPOCH_BITS-1:0]  tail_epoch;

  // Reference model
  logic [DATA_BITS-1:0]   expected_table [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] pending;
  int                     accept_count;
  int                     return_count;
  result_t                returned [$];
  logic [31:0]            rng_state;

  seq_tracker seq_tracker_i (
    .clk         (clk),
    .rst         (rst),
    .inst_val    (inst_val),
    .inst_rdy    (inst_rdy),
    .inst        (inst),
    .res_val     (res_val),
    .res_rdy     (res_rdy),
    .res_data    (res_data),
    .res_seq_num (res_seq_num),
    .tail_epoch  (tail_epoch)
  );

  bind seq_tracker seq_tracker_properties seq_tracker_properties_i (
    .clk         (clk),
    .rst         (rst),
    .inst_val    (inst_val),
    .inst_rdy    (inst_rdy),
    .res_val     (res_val),
    .res_rdy     (res_rdy),
    .res_data    (res_data),
    .res_seq_num (res_seq_num)
  );

  always #CLK_HALF clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [INST_BITS-1:0] make_inst(input op_t op,
                                                     input logic [OPND_BITS-1:0] a,
                                                     input logic [OPND_BITS-1:0] b);
    return {op, a, b};
  endfunction

  function automatic logic [INST_BITS-1:0] random_inst();
    logic [31:0] r;
    r = next_random();
    return r[INST_BITS-1:0];
  endfunction

  // Operands zero-extended, results kept modulo 2^16
  function automatic logic [DATA_BITS-1:0] model_result(input logic [INST_BITS-1:0] word);
    logic [DATA_BITS-1:0] a;
    logic [DATA_BITS-1:0] b;
    a = DATA_BITS'(word[2*OPND_BITS-1:OPND_BITS]);
    b = DATA_BITS'(word[OPND_BITS-1:0]);
    case (op_t'(word[INST_BITS-1 -: 2]))
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return a * b;
    endcase
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_result(input result_t actual, input result_t expected);
    if (actual.data !== expected.data) begin
      report_failure($sformatf("MISMATCH res_data: got 0x%h expected 0x%h",
                               actual.data, expected.data));
    end else if (actual.seq_num !== expected.seq_num) begin
      report_failure($sformatf("MISMATCH res_seq_num: got 0x%h expected 0x%h",
                               actual.seq_num, expected.seq_num));
    end
  endtask

  task automatic compare_epoch(input logic [EPOCH_BITS-1:0] actual,
                               input logic [EPOCH_BITS-1:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH tail_epoch: got 0x%h expected 0x%h",
                               actual, expected));
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, actual, expected));
    end
  endtask

  // Called at a rising edge, returns at the edge of the transfer
  task automatic send_inst(input logic [INST_BITS-1:0] word);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    inst_val <= 1'b1;
    inst     <= word;
    while (!taken) begin
      @(negedge clk);
      taken = inst_rdy;
      @(posedge clk);
      cycles++;
      if (!taken && cycles > WAIT_LIMIT) begin
        report_failure("Timed out waiting for inst_rdy");
      end
    end
    inst_val <= 1'b0;
  endtask

  task automatic wait_for_returns(input int target);
    int cycles;
    cycles = 0;
    while (return_count < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure("Timed out waiting for results to come back");
      end
    end
  endtask

  // ------------------------------
  // Model and result monitor
  // ------------------------------

  // Sampled mid-cycle, where every handshake signal is settled
  always @(negedge clk) begin
    seq_num_t seq;
    result_t  got;
    result_t  expected;
    if (!rst) begin
      if (inst_val && inst_rdy) begin
        // Numbers go out in order from 0
        seq = seq_num_t'(accept_count % NUM_ENTRIES);
        if (pending[seq]) begin
          report_failure($sformatf("Sequence number %0d handed out twice", seq));
        end
        pending[seq]        = 1'b1;
        expected_table[seq] = model_result(inst);
        accept_count++;
      end
      if (res_val && res_rdy) begin
        if (!pending[res_seq_num]) begin
          report_failure($sformatf("Result for number %0d that is not outstanding",
                                   res_seq_num));
        end
        got.data         = res_data;
        got.seq_num      = res_seq_num;
        expected.data    = expected_table[res_seq_num];
        expected.seq_num = res_seq_num;
        compare_result(got, expected);
        pending[res_seq_num] = 1'b0;
        returned.push_back(got);
        return_count++;
      end
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic test_reset_state();
    @(negedge clk);
    compare_flag("res_val", res_val, 1'b0);
    compare_epoch(tail_epoch, '0);
    @(posedge clk);
  endtask

  task automatic test_each_opcode();
    op_t                  ops [4];
    logic [31:0]          r;
    logic [INST_BITS-1:0] word;
    result_t              expected;
    int                   base;
    ops = '{OP_ADD, OP_SUB, OP_XOR, OP_MUL};
    foreach (ops[i]) begin
      r    = next_random();
      word = make_inst(ops[i], r[15:8], r[7:0]);
      expected.seq_num = seq_num_t'(accept_count % NUM_ENTRIES);
      expected.data    = model_result(word);
      base = return_count;
      send_inst(word);
      wait_for_returns(base + 1);
      compare_result(returned[base], expected);
    end
  endtask

  // Short ALU op overtakes the multiply issued one cycle earlier
  task automatic test_out_of_order();
    logic [31:0]          r;
    logic [INST_BITS-1:0] mul_word;
    logic [INST_BITS-1:0] add_word;
    result_t              mul_exp;
    result_t              add_exp;
    int                   base;
    r        = next_random();
    mul_word = make_inst(OP_MUL, r[31:24], r[23:16]);
    add_word = make_inst(OP_ADD, r[15:8], r[7:0]);
    mul_exp.seq_num = seq_num_t'(accept_count % NUM_ENTRIES);
    mul_exp.data    = model_result(mul_word);
    add_exp.seq_num = mul_exp.seq_num + 1'b1;
    add_exp.data    = model_result(add_word);
    base = return_count;
    send_inst(mul_word);
    send_inst(add_word);
    wait_for_returns(base + 2);
    compare_result(returned[base], add_exp);
    compare_result(returned[base + 1], mul_exp);
  endtask

  task automatic test_window_limit();
    int   start;
    int   cycles;
    logic taken;
    start = accept_count;
    taken = 1'b0;
    res_rdy  <= 1'b0;
    inst_val <= 1'b1;
    inst     <= random_inst();
    for (cycles = 0; cycles < STALL_CYCLES; cycles++) begin
      @(negedge clk);
      taken = inst_rdy;
      @(posedge clk);
      if (taken) begin
        inst <= random_inst();
      end
      if (accept_count - start > NUM_ENTRIES - 1) begin
        report_failure("More than 15 instructions accepted while res_rdy was low");
      end
    end
    if (taken) begin
      report_failure("inst_rdy still high after a long stall on res_rdy");
    end
    res_rdy <= 1'b1;
    // The last word stays offered until it gets in
    cycles = 0;
    while (!taken) begin
      @(negedge clk);
      taken = inst_rdy;
      @(posedge clk);
      cycles++;
      if (!taken && cycles > WAIT_LIMIT) begin
        report_failure("Input acceptance did not resume after res_rdy went high");
      end
    end
    inst_val <= 1'b0;
    wait_for_returns(accept_count);
  endtask

  task automatic test_reclaim_epoch();
    int                    sizes [3];
    int                    cycles;
    seq_num_t              head;
    logic [EPOCH_BITS-1:0] expected;
    sizes = '{5, 9, 16};
    foreach (sizes[i]) begin
      for (int k = 0; k < sizes[i]; k++) begin
        send_inst(random_inst());
      end
      wait_for_returns(accept_count);
      // Drained, so the tail catches up with the head
      head     = seq_num_t'(accept_count % NUM_ENTRIES);
      expected = head[SEQ_NUM_BITS-1 -: EPOCH_BITS];
      cycles   = 0;
      do begin
        @(negedge clk);
        cycles++;
      end while (tail_epoch !== expected && cycles < NUM_ENTRIES);
      compare_epoch(tail_epoch, expected);
      @(posedge clk);
    end
  endtask

  task automatic test_random_stream();
    int          sent;
    int          idle;
    logic        taken;
    logic [31:0] r;
    sent = 0;
    idle = 0;
    inst_val <= 1'b1;
    inst     <= random_inst();
    while (sent < STREAM_COUNT) begin
      @(negedge clk);
      taken = inst_rdy;
      @(posedge clk);
      r = next_random();
      // Consumer ready about three cycles in four
      res_rdy <= (r[1:0] != 2'b00);
      if (taken) begin
        sent++;
        idle = 0;
        if (sent < STREAM_COUNT) begin
          inst <= random_inst();
        end else begin
          inst_val <= 1'b0;
        end
      end else begin
        idle++;
        if (idle > WAIT_LIMIT) begin
          report_failure("Timed out waiting for inst_rdy in the random stream");
        end
      end
    end
    res_rdy <= 1'b1;
    wait_for_returns(accept_count);
    if (pending != '0) begin
      report_failure("Some sequence numbers were never returned");
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    inst_val     = 1'b0;
    inst         = '0;
    res_rdy      = 1'b0;
    rng_state    = 32'h355e_eae9;
    accept_count = 0;
    return_count = 0;
    pending      = '0;
    repeat (4) @(posedge clk);
    rst     <= 1'b0;
    res_rdy <= 1'b1;
    test_reset_state();
    test_each_opcode();
    test_out_of_order();
    test_window_limit();
    test_reclaim_epoch();
    test_random_stream();
    $display("No errors");
    $finish;
  end

endmodule

// File: seq_tracker.f
logic/seq_pkg.sv
logic/sequencing_unit.sv
logic/skid_buffer.sv
logic/op_decode.sv
logic/op_execute.sv
logic/result_writeback.sv
logic/seq_tracker.sv
tests/seq_tracker_properties.sv
tests/seq_tracker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the sequence tracker testbench with Verilator, runs it, then scans the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module seq_tracker_tb -f seq_tracker.f --Mdir obj_dir \
  > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "Build failed"; exit 1; }

./obj_dir/Vseq_tracker_tb > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "Errors found" "$SIM_LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" "$SIM_LOG" || { echo "Simulation ended early"; exit 1; }
echo "Simulation passed"
